/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
   --top-module tb_periph_subsystem -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

/* sim.f */
+incdir+include
verilog/periph_pkg.sv
verilog/apb_slave_if.sv
verilog/apb_interconnect.sv
verilog/apb_timer.sv
verilog/apb_pwm.sv
verilog/apb_gpio.sv
verilog/periph_subsystem.sv
tb/periph_props.sv
tb/tb_periph_subsystem.sv

/* tb/periph_patterns.txt */
# columns: test name, op, address, data, expected (numbers in hex)
# ops: wr write, rd read, er unmapped access, pn pin (addr 0 gpio_o 1 gpio_oe_o 2 irq_o 3 pwm_o 4 pwm_en_o)
# gi gpio input rounds, iq wait for irq_o level, ih hold irq_o level, pw pwm_o high count; data = rounds or cycles
reset_state rd 2000 0 0
reset_state rd 2004 0 0
reset_state rd 2008 0 0
reset_state rd 200c 0 0
reset_state rd 4000 0 0
reset_state rd 4004 0 0
reset_state rd 4008 0 0
reset_state rd 8000 0 0
reset_state rd 8004 0 0
reset_state rd 8008 0 0
reset_state pn 2 0 0
reset_state pn 3 0 0
reset_state pn 4 0 0
reset_state pn 1 0 0
readback wr 2008 1234abcd 0
readback rd 2008 0 1234abcd
readback wr 4004 9 0
readback wr 4008 4 0
readback rd 4004 0 9
readback rd 4008 0 4
readback wr 8000 a5 0
readback wr 8004 3c 0
readback rd 8000 0 a5
readback rd 8004 0 3c
readback pn 0 0 a5
readback pn 1 0 3c
readback rd 2010 0 0
readback wr 8010 ff 0
readback rd 8010 0 0
unmapped er 6000 55 0
unmapped er a004 aa 0
unmapped rd 8000 0 a5
timer_irq wr 2008 a 0
timer_irq wr 2004 0 0
timer_irq wr 2000 3 0
timer_irq iq 0 40 1
timer_irq rd 200c 0 1
timer_irq wr 2000 2 0
timer_irq wr 200c 1 0
timer_irq iq 0 4 0
timer_irq rd 200c 0 0
timer_no_ie wr 2004 0 0
timer_no_ie wr 2000 1 0
timer_no_ie ih 0 1e 0
timer_no_ie rd 200c 0 1
timer_no_ie pn 2 0 0
timer_no_ie wr 2000 0 0
pwm_duty wr 4004 5 0
pwm_duty wr 4008 2 0
pwm_duty wr 4000 1 0
pwm_duty pn 4 0 1
pwm_duty pw 0 14 8
pwm_duty wr 4008 0 0
pwm_duty pw 0 14 0
pwm_duty wr 4008 7 0
pwm_duty pw 0 14 14
pwm_duty wr 4000 0 0
pwm_duty pn 4 0 0
gpio_in gi 0 6 0

/* tb/periph_props.sv */
// APB protocol assertions bound into the interconnect
`timescale 1ns/1ns

module periph_props (
   input logic clk,
   input logic psel_i,
   input logic penable_i,
   input logic pready_i,     // Interconnect pready_o
   input logic pslverr_i,    // Interconnect pslverr_o
   input logic hit_tmr_i,
   input logic hit_pwm_i,
   input logic hit_gpio_i
);

   // Ready only in the access cycle right after its setup cycle
   a_ready_access: assert property (@(posedge clk)
      pready_i |-> (psel_i && penable_i && $past(psel_i && !penable_i)))
      else $error("pready_o high outside the access cycle of a two-cycle transfer");

   // Error only for a window that was already unmapped in the setup cycle
   a_err_ready: assert property (@(posedge clk)
      pslverr_i |-> (pready_i && $past(!(hit_tmr_i || hit_pwm_i || hit_gpio_i))))
      else $error("pslverr_o high without pready_o or for a mapped setup address");

   // Slot selects
   a_one_slot: assert property (@(posedge clk)
      (psel_i && penable_i) |->
         ($onehot0({psel_i & hit_tmr_i, psel_i & hit_pwm_i, psel_i & hit_gpio_i})
          && $stable({hit_tmr_i, hit_pwm_i, hit_gpio_i})))
      else $error("slot select not unique or changed between setup and access");

endmodule

/* include/periph_defs.svh */
// Peripheral window bases, register offsets and bus widths for the testbench
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

`define APB_ADDR_W     16
`define APB_DATA_W     32

// ********************
// Window bases
`define TIMER_BASE     16'h2000
`define PWM_BASE       16'h4000
`define UART_BASE      16'h6000  // Unmapped, answers with error
`define GPIO_BASE      16'h8000
`define SPI_BASE       16'hA000  // Unmapped, answers with error

// Register offsets
`define TMR_CTRL       16'h0000
`define TMR_COUNT      16'h0004
`define TMR_CMP        16'h0008
`define TMR_STAT       16'h000C
`define PWM_CTRL       16'h0000
`define PWM_PERIOD     16'h0004
`define PWM_DUTY       16'h0008
`define GPIO_OUT       16'h0000
`define GPIO_OE        16'h0004
`define GPIO_IN        16'h0008

`endif

/* tb/tb_periph_subsystem.sv */
// Testbench with clock, reset, APB driver, pattern reader, step checks and report
`timescale 1ns/1ns
`include "periph_defs.svh"

module tb_periph_subsystem
   import periph_pkg::*;
();

   localparam int apb_timeout = 8;     // Cycles allowed for pready_o

   logic      clk;
   logic      rst_n_i;
   logic      psel_i;
   logic      penable_i;
   logic      pwrite_i;
   apb_addr_t paddr_i;
   apb_data_t pwdata_i;
   apb_data_t prdata_o;
   logic      pready_o;
   logic      pslverr_o;
   logic      irq_o;
   logic      pwm_o;
   logic      pwm_en_o;
   gpio_t     gpio_i;
   gpio_t     gpio_o;
   gpio_t     gpio_oe_o;

   logic [31:0]  lfsr_q;
   logic         hung;               // Set on a timeout to end the run
   logic [127:0] cur_name;
   int           errors;
   int           test_errors;
   int           steps;
   int           tests_run;
   int           tests_bad;

   periph_subsystem u_periph_subsystem (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .irq_o     (irq_o),
      .pwm_o     (pwm_o),
      .pwm_en_o  (pwm_en_o),
      .gpio_i    (gpio_i),
      .gpio_o    (gpio_o),
      .gpio_oe_o (gpio_oe_o)
   );

   bind apb_interconnect periph_props u_periph_props (
      .clk        (clk),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pready_i   (pready_o),
      .pslverr_i  (pslverr_o),
      .hit_tmr_i  (hit_tmr),
      .hit_pwm_i  (hit_pwm),
      .hit_gpio_i (hit_gpio)
   );

   always #4 clk = ~clk;

   // ********************
   // Helpers
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Galois form
   endfunction

   task automatic draw_pins(output gpio_t v);
      for (int i = 0; i < gpio_pins; i++) begin
         v[i] = lfsr_q[0];
         lfsr_q = lfsr_next(lfsr_q);   // One step per bit
      end
   endtask

   task automatic show_mismatch(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
      errors++;
      test_errors++;
      $display("mismatch %0s %0s: expected %h actual %h", cur_name, what, exp, act);
   endtask

   task automatic fail_step(input string msg);
      errors++;
      test_errors++;
      $display("%0s: %0s", cur_name, msg);
   endtask

   // Setup and access cycle entered and left 1 ns after a rising edge
   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                           output apb_data_t rdata, output logic err);
      int waited;
      waited = 0;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = addr;
      pwdata_i  = wdata;
      #1;
      if (pready_o !== 1'b0) fail_step("pready_o high in the setup cycle");
      @(posedge clk);
      #1 penable_i = 1'b1;
      #2;
      while (pready_o !== 1'b1 && waited < apb_timeout) begin
         @(posedge clk);
         #3;
         waited++;
      end
      if (pready_o !== 1'b1) begin
         fail_step("timeout, pready_o never rose in the access cycle");
         hung = 1'b1;
      end
      rdata = prdata_o;
      err   = pslverr_o;
      @(posedge clk);   // Write lands here
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   // ********************
   // One pattern line
   task automatic run_step(input logic [15:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
      apb_data_t rdata;
      logic      err;
      gpio_t     pins;
      logic [31:0] act;
      int        cnt;
      cnt = 0;
      case (op)
         "wr": begin
            apb_xfer(1'b1, addr[15:0], data, rdata, err);
            if (err !== 1'b0) show_mismatch("pslverr_o", 32'h0, {31'h0, err});
         end
         "rd": begin
            apb_xfer(1'b0, addr[15:0], 32'h0, rdata, err);
            if (err !== 1'b0) show_mismatch("pslverr_o", 32'h0, {31'h0, err});
            if (rdata !== exp) show_mismatch("read data", exp, rdata);
         end
         "er": begin   // Unmapped window in both directions
            apb_xfer(1'b1, addr[15:0], data, rdata, err);
            if (err !== 1'b1) show_mismatch("pslverr_o on write", 32'h1, {31'h0, err});
            apb_xfer(1'b0, addr[15:0], 32'h0, rdata, err);
            if (err !== 1'b1) show_mismatch("pslverr_o on read", 32'h1, {31'h0, err});
            if (rdata !== exp) show_mismatch("read data", exp, rdata);
         end
         "pn": begin
            case (addr[2:0])
               3'd0: act = apb_data_t'(gpio_o);
               3'd1: act = apb_data_t'(gpio_oe_o);
               3'd2: act = {31'h0, irq_o};
               3'd3: act = {31'h0, pwm_o};
               default: act = {31'h0, pwm_en_o};
            endcase
            if (act !== exp) show_mismatch("pin level", exp, act);
         end
         "gi": begin
            repeat (data) begin
               draw_pins(pins);
               gpio_i = pins;
               repeat (sync_stages + 1) @(posedge clk);
               #1;
               apb_xfer(1'b0, `GPIO_BASE + `GPIO_IN, 32'h0, rdata, err);
               if (rdata !== apb_data_t'(pins)) begin
                  show_mismatch("gpio IN", apb_data_t'(pins), rdata);
               end
            end
         end
         "iq": begin
            while (irq_o !== exp[0] && cnt < data) begin
               @(posedge clk);
               #1;
               cnt++;
            end
            if (irq_o !== exp[0]) begin
               fail_step("timeout, irq_o never reached the expected level");
               hung = 1'b1;
            end
         end
         "ih": begin
            repeat (data) begin
               @(posedge clk);
               #1;
               if (irq_o !== exp[0]) cnt++;
            end
            if (cnt != 0) show_mismatch("cycles off the irq_o level", 32'h0, cnt);
         end
         "pw": begin   // Sampled once per cycle after the edge
            repeat (data) begin
               @(posedge clk);
               #1;
               if (pwm_o === 1'b1) cnt++;
            end
            if (cnt != exp) show_mismatch("pwm_o high cycles", exp, cnt);
         end
         default: fail_step("unknown operation code in the pattern file");
      endcase
   endtask

   task automatic close_test();
      tests_run++;
      if (test_errors != 0) tests_bad++;
      $display("%0s done, %0d steps, %0d errors", cur_name, steps, test_errors);
      test_errors = 0;
      steps = 0;
   endtask

   // ********************
   // Main sequence
   initial begin
      int           fd;
      int           n;
      string        line;
      logic [127:0] name_v;
      logic [15:0]  op_v;
      logic [31:0]  addr_v;
      logic [31:0]  data_v;
      logic [31:0]  exp_v;
      clk       = 1'b0;
      rst_n_i   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      gpio_i    = '0;
      lfsr_q    = 32'h874f1489;
      hung      = 1'b0;
      cur_name  = '0;
      errors    = 0;
      test_errors = 0;
      steps     = 0;
      tests_run = 0;
      tests_bad = 0;
      repeat (4) @(posedge clk);
      #1 rst_n_i = 1'b1;

      fd = $fopen("tb/periph_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open tb/periph_patterns.txt");
         hung = 1'b1;
      end
      while (!hung && fd != 0 && !$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 2 && line.getc(0) != "#") begin   // Skip comments
            n = $sscanf(line, "%s %s %h %h %h", name_v, op_v, addr_v, data_v, exp_v);
            if (n == 5) begin
               if (name_v != cur_name && cur_name != '0) close_test();
               cur_name = name_v;
               steps++;
               run_step(op_v, addr_v, data_v, exp_v);
            end
         end
      end
      if (cur_name != '0) close_test();
      if (fd != 0) $fclose(fd);

      $display("summary: %0d tests, %0d with errors, %0d errors", tests_run, tests_bad, errors);
      if (!hung && errors == 0 && tests_run > 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* verilog/apb_gpio.sv */
// GPIO with output data and enable registers and a synchronized input register
`timescale 1ns/1ns

module apb_gpio
   import periph_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   apb_slave_if.slave bus,
   input  gpio_t      gpio_i,
   output gpio_t      gpio_o,
   output gpio_t      gpio_oe_o
);

   gpio_t                   out_q;
   gpio_t                   oe_q;
   gpio_t [sync_stages-1:0] sync_q;   // Metastability chain, [0] sees the pins
   gpio_t                   in_q;

   logic  wr_en;
   logic  wr_out;
   logic  wr_oe;

   assign wr_en  = bus.psel & bus.penable & bus.pwrite;
   assign wr_out = wr_en && (bus.paddr == gpio_out_off);
   assign wr_oe  = wr_en && (bus.paddr == gpio_oe_off);

   // ********************
   // Pin side
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         out_q  <= '0;
         oe_q   <= '0;
         sync_q <= '0;
         in_q   <= '0;
      end else begin
         if (wr_out) out_q <= bus.pwdata[gpio_pins-1:0];
         if (wr_oe) oe_q <= bus.pwdata[gpio_pins-1:0];
         sync_q <= {sync_q[sync_stages-2:0], gpio_i};
         in_q   <= sync_q[sync_stages-1];  // IN register, one edge after the chain
      end
   end

   assign gpio_o    = out_q;
   assign gpio_oe_o = oe_q;

   // IN ignores writes
   always_comb begin
      case (bus.paddr)
         gpio_out_off: bus.prdata = apb_data_t'(out_q);
         gpio_oe_off:  bus.prdata = apb_data_t'(oe_q);
         gpio_in_off:  bus.prdata = apb_data_t'(in_q);
         default:      bus.prdata = '0;
      endcase
   end

endmodule

/* verilog/apb_interconnect.sv */
// APB address decode, slot selects, read-data return and error response
`timescale 1ns/1ns

module apb_interconnect
   import periph_pkg::*;
(
   input  logic        clk,        // Bus clock, sampled by the bound protocol checks
   input  logic        psel_i,
   input  logic        penable_i,
   input  logic        pwrite_i,
   input  apb_addr_t   paddr_i,
   input  apb_data_t   pwdata_i,
   output apb_data_t   prdata_o,
   output logic        pready_o,
   output logic        pslverr_o,
   apb_slave_if.master tmr_o,
   apb_slave_if.master pwm_o,
   apb_slave_if.master gpio_o
);

   slot_t slot;
   logic  hit_tmr;
   logic  hit_pwm;
   logic  hit_gpio;
   logic  mapped;
   logic  access;

   // ********************
   // Window decode
   assign slot     = paddr_i[apb_addr_w-1 -: slot_w];
   assign hit_tmr  = (slot == slot_timer);
   assign hit_pwm  = (slot == slot_pwm);
   assign hit_gpio = (slot == slot_gpio);
   assign mapped   = hit_tmr | hit_pwm | hit_gpio;

   // Second cycle of every transfer
   assign access = psel_i & penable_i;

   // ********************
   // Slot fan-out
   assign tmr_o.psel    = psel_i & hit_tmr;
   assign tmr_o.penable = penable_i;
   assign tmr_o.pwrite  = pwrite_i;
   assign tmr_o.paddr   = paddr_i[reg_off_w-1:0];
   assign tmr_o.pwdata  = pwdata_i;

   assign pwm_o.psel    = psel_i & hit_pwm;
   assign pwm_o.penable = penable_i;
   assign pwm_o.pwrite  = pwrite_i;
   assign pwm_o.paddr   = paddr_i[reg_off_w-1:0];
   assign pwm_o.pwdata  = pwdata_i;

   assign gpio_o.psel    = psel_i & hit_gpio;
   assign gpio_o.penable = penable_i;
   assign gpio_o.pwrite  = pwrite_i;
   assign gpio_o.paddr   = paddr_i[reg_off_w-1:0];
   assign gpio_o.pwdata  = pwdata_i;

   // ********************
   // Response path
   always_comb begin
      unique case (slot)
         slot_timer: prdata_o = tmr_o.prdata;
         slot_pwm:   prdata_o = pwm_o.prdata;
         slot_gpio:  prdata_o = gpio_o.prdata;
         default:    prdata_o = '0;  // Old UART and SPI windows land here
      endcase
   end

   // No wait states in any slot
   assign pready_o  = access;
   assign pslverr_o = access & ~mapped;

endmodule

/* verilog/apb_pwm.sv */
// PWM with control, period and duty registers and a registered compare output
`timescale 1ns/1ns

module apb_pwm
   import periph_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   apb_slave_if.slave bus,
   output logic       pwm_o,
   output logic       pwm_en_o
);

   logic      en_q;
   apb_data_t period_q;
   apb_data_t duty_q;
   apb_data_t cnt_q;      // Position inside the period
   logic      pwm_q;

   logic      wr_en;
   logic      wr_ctrl;
   logic      wr_period;
   logic      wr_duty;

   assign wr_en     = bus.psel & bus.penable & bus.pwrite;
   assign wr_ctrl   = wr_en && (bus.paddr == pwm_ctrl_off);
   assign wr_period = wr_en && (bus.paddr == pwm_period_off);
   assign wr_duty   = wr_en && (bus.paddr == pwm_duty_off);

   // ********************
   // Registers
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         en_q     <= 1'b0;
         period_q <= '0;
         duty_q   <= '0;
      end else begin
         if (wr_ctrl) en_q <= bus.pwdata[pwm_en_bit];
         if (wr_period) period_q <= bus.pwdata;
         if (wr_duty) duty_q <= bus.pwdata;
      end
   end

   // Period counter and output compare
   always_ff @(posedge clk) begin
      if (!rst_n_i || !en_q) begin
         cnt_q <= '0;
         pwm_q <= 1'b0;
      end else begin
         if (cnt_q + 1'b1 >= period_q) begin
            cnt_q <= '0;               // Wrap after period-1
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
         pwm_q <= (cnt_q < duty_q);
      end
   end

   assign pwm_o    = pwm_q;
   assign pwm_en_o = en_q;

   always_comb begin
      case (bus.paddr)
         pwm_ctrl_off:   bus.prdata = apb_data_t'(en_q) << pwm_en_bit;
         pwm_period_off: bus.prdata = period_q;
         pwm_duty_off:   bus.prdata = duty_q;
         default:        bus.prdata = '0;
      endcase
   end

endmodule

/* verilog/apb_slave_if.sv */
// APB slot interface between the interconnect and one peripheral
`timescale 1ns/1ns

interface apb_slave_if
   import periph_pkg::*;
();

   logic      psel;      // Slot select, one window only
   logic      penable;   // Access phase
   logic      pwrite;
   reg_off_t  paddr;     // Offset inside the window
   apb_data_t pwdata;
   apb_data_t prdata;    // Combinational read data from the peripheral

   // Interconnect side
   modport master (
      output psel,
      output penable,
      output pwrite,
      output paddr,
      output pwdata,
      input  prdata
   );

   // Peripheral side
   modport slave (
      input  psel,
      input  penable,
      input  pwrite,
      input  paddr,
      input  pwdata,
      output prdata
   );

endinterface

/* verilog/apb_timer.sv */
// Timer with control, count, compare and status registers and a match interrupt
`timescale 1ns/1ns

module apb_timer
   import periph_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   apb_slave_if.slave bus,
   output logic       irq_o
);

   logic [1:0] ctrl_q;     // Interrupt enable and counter enable
   apb_data_t  count_q;
   apb_data_t  cmp_q;
   logic       match_q;    // Sticky match flag
   logic       irq_q;

   logic       wr_en;
   logic       wr_ctrl;
   logic       wr_count;
   logic       wr_cmp;
   logic       wr_stat;
   logic       hit;

   assign wr_en    = bus.psel & bus.penable & bus.pwrite;
   assign wr_ctrl  = wr_en && (bus.paddr == tmr_ctrl_off);
   assign wr_count = wr_en && (bus.paddr == tmr_count_off);
   assign wr_cmp   = wr_en && (bus.paddr == tmr_cmp_off);
   assign wr_stat  = wr_en && (bus.paddr == tmr_stat_off);

   assign hit = ctrl_q[tmr_en_bit] && (count_q == cmp_q);

   // ********************
   // Registers and counter
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ctrl_q  <= '0;
         count_q <= '0;
         cmp_q   <= '0;
         match_q <= 1'b0;
         irq_q   <= 1'b0;
      end else begin
         if (wr_ctrl) begin
            ctrl_q <= bus.pwdata[1:0];
         end
         if (wr_cmp) begin
            cmp_q <= bus.pwdata;
         end
         if (wr_count) begin
            count_q <= bus.pwdata;   // Software load wins
         end else if (hit) begin
            count_q <= '0;
         end else if (ctrl_q[tmr_en_bit]) begin
            count_q <= count_q + 1'b1;
         end
         // A new match beats a clear in the same cycle
         if (hit) begin
            match_q <= 1'b1;
         end else if (wr_stat && bus.pwdata[tmr_match_bit]) begin
            match_q <= 1'b0;
         end
         irq_q <= match_q & ctrl_q[tmr_ie_bit];
      end
   end

   assign irq_o = irq_q;

   // Read mux, no side effects
   always_comb begin
      case (bus.paddr)
         tmr_ctrl_off:  bus.prdata = apb_data_t'(ctrl_q);
         tmr_count_off: bus.prdata = count_q;
         tmr_cmp_off:   bus.prdata = cmp_q;
         tmr_stat_off:  bus.prdata = apb_data_t'(match_q) << tmr_match_bit;
         default:       bus.prdata = '0;
      endcase
   end

endmodule

/* verilog/periph_pkg.sv */
// Bus widths and types, address map, register offsets and field positions
package periph_pkg;

   // ********************
   // APB bus
   localparam int apb_addr_w = 16;
   localparam int apb_data_w = 32;

   typedef logic [apb_addr_w-1:0] apb_addr_t;
   typedef logic [apb_data_w-1:0] apb_data_t;

   // ********************
   // Address map
   localparam int slot_w = 3;                 // Window number in paddr[15:13]
   typedef logic [slot_w-1:0] slot_t;

   localparam slot_t slot_timer = 3'd1;       // 0x2000
   localparam slot_t slot_pwm   = 3'd2;       // 0x4000
   localparam slot_t slot_gpio  = 3'd4;       // 0x8000

   localparam int reg_off_w = 8;              // Offset inside a window
   typedef logic [reg_off_w-1:0] reg_off_t;

   // Timer registers
   localparam reg_off_t tmr_ctrl_off  = 8'h00;
   localparam reg_off_t tmr_count_off = 8'h04;
   localparam reg_off_t tmr_cmp_off   = 8'h08;
   localparam reg_off_t tmr_stat_off  = 8'h0C;
   localparam int tmr_en_bit    = 0;          // CTRL
   localparam int tmr_ie_bit    = 1;          // CTRL
   localparam int tmr_match_bit = 0;          // STAT, write 1 clears

   // PWM registers
   localparam reg_off_t pwm_ctrl_off   = 8'h00;
   localparam reg_off_t pwm_period_off = 8'h04;
   localparam reg_off_t pwm_duty_off   = 8'h08;
   localparam int pwm_en_bit = 0;

   // GPIO registers
   localparam reg_off_t gpio_out_off = 8'h00;
   localparam reg_off_t gpio_oe_off  = 8'h04;
   localparam reg_off_t gpio_in_off  = 8'h08;  // Read only

   localparam int gpio_pins   = 8;
   localparam int sync_stages = 2;
   typedef logic [gpio_pins-1:0] gpio_t;

endpackage

/* verilog/periph_subsystem.sv */
// Peripheral subsystem top with APB interconnect, timer, PWM and GPIO
`timescale 1ns/1ns

module periph_subsystem
   import periph_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,

   // APB slave port
   input  logic      psel_i,
   input  logic      penable_i,
   input  logic      pwrite_i,
   input  apb_addr_t paddr_i,
   input  apb_data_t pwdata_i,
   output apb_data_t prdata_o,
   output logic      pready_o,
   output logic      pslverr_o,

   // Pins
   output logic      irq_o,       // Timer match interrupt
   output logic      pwm_o,
   output logic      pwm_en_o,
   input  gpio_t     gpio_i,
   output gpio_t     gpio_o,
   output gpio_t     gpio_oe_o
);

   // ********************
   // Slot buses
   apb_slave_if tmr_bus ();
   apb_slave_if pwm_bus ();
   apb_slave_if gpio_bus ();

   apb_interconnect u_apb_interconnect (
      .clk       (clk),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .tmr_o     (tmr_bus.master),
      .pwm_o     (pwm_bus.master),
      .gpio_o    (gpio_bus.master)
   );

   // ********************
   // Peripherals
   apb_timer u_apb_timer (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (tmr_bus.slave),
      .irq_o   (irq_o)
   );

   apb_pwm u_apb_pwm (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .bus      (pwm_bus.slave),
      .pwm_o    (pwm_o),
      .pwm_en_o (pwm_en_o)
   );

   apb_gpio u_apb_gpio (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .bus       (gpio_bus.slave),
      .gpio_i    (gpio_i),
      .gpio_o    (gpio_o),
      .gpio_oe_o (gpio_oe_o)
   );

endmodule
